// ==== include/l2_cfg.svh ====
/* L2 input stage configuration.
   Address split, cache geometry and request slot sizes. */

`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// Byte address and line offset split.
`define ADDR_BITS 32
`define OFFSET_BITS 4
`define W_OFF_BITS 2
`define B_OFF_BITS 2

// Cache geometry.
`define L2_SET_BITS 4
`define L2_SETS 16
`define L2_WAY_BITS 2
`define L2_WAYS 4

`define L2_TAG_BITS (`ADDR_BITS - `OFFSET_BITS - `L2_SET_BITS)

// Request slots, counter wide enough to hold N_REQS.
`define N_REQS 4
`define REQS_BITS_P1 3

`endif

// ==== source/l2_pkg.sv ====
/* L2 input stage types: addresses, breakdown structs and operation kinds. */

`include "l2_cfg.svh"

package l2_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`ADDR_BITS-`OFFSET_BITS-1:0] line_addr_t;
    typedef logic [`L2_TAG_BITS-1:0] tag_t;
    typedef logic [`L2_SET_BITS-1:0] set_t;
    typedef logic [`L2_WAY_BITS-1:0] way_t;
    typedef logic [`W_OFF_BITS-1:0] w_off_t;
    typedef logic [`B_OFF_BITS-1:0] b_off_t;

    typedef struct packed {
        tag_t tag;
        set_t set;
    } line_breakdown_t;

    typedef struct packed {
        addr_t      line;       // Byte address with the line offset cleared.
        line_addr_t line_addr;
        addr_t      word;       // Byte address with the byte offset cleared.
        tag_t       tag;
        set_t       set;
        w_off_t     w_off;
        b_off_t     b_off;
    } addr_breakdown_t;

    typedef enum logic [1:0] {
        OP_FLUSH_WAY = 2'd0,
        OP_RSP       = 2'd1,
        OP_FWD       = 2'd2,
        OP_CPU_REQ   = 2'd3
    } l2_op_t;

    function automatic line_breakdown_t break_line(line_addr_t la);
        line_breakdown_t br;
        br.tag = la[`ADDR_BITS-`OFFSET_BITS-1:`L2_SET_BITS];
        br.set = la[`L2_SET_BITS-1:0];
        return br;
    endfunction

    function automatic addr_breakdown_t break_addr(addr_t addr);
        addr_breakdown_t br;
        br.line      = {addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
        br.line_addr = addr[`ADDR_BITS-1:`OFFSET_BITS];
        br.word      = {addr[`ADDR_BITS-1:`B_OFF_BITS], {`B_OFF_BITS{1'b0}}};
        br.tag       = addr[`ADDR_BITS-1:`OFFSET_BITS+`L2_SET_BITS];
        br.set       = addr[`OFFSET_BITS+`L2_SET_BITS-1:`OFFSET_BITS];
        br.w_off     = addr[`OFFSET_BITS-1:`B_OFF_BITS];
        br.b_off     = addr[`B_OFF_BITS-1:0];
        return br;
    endfunction

endpackage

// ==== source/l2_input_fifo.sv ====
/* Small valid/ready input buffer.
   Circular store of DEPTH entries, push and pop in the same cycle allowed. */

`timescale 1ns/1ps

module l2_input_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t              mem [DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != CNT_BITS'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    // A push turned away by a full buffer must be offered again.
    a_full_push_held: assert property (@(posedge clk) disable iff (!rst)
        (in_valid && !in_ready) |=> in_valid);

endmodule

// ==== source/l2_flush_walker.sv ====
/* Flush walk state.
   Flush-in-progress flag and the current set and way of the walk. */

`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_flush_walker import l2_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    set_ongoing_flush,
    input  logic                    clr_ongoing_flush,
    input  logic                    incr_flush_way,
    input  logic                    incr_flush_set,
    input  logic                    clr_flush,
    output logic                    ongoing_flush,
    output logic [`L2_SET_BITS:0]   flush_set,
    output way_t                    flush_way
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ongoing_flush <= 1'b0;
        end else if (set_ongoing_flush) begin
            ongoing_flush <= 1'b1;
        end else if (clr_ongoing_flush) begin
            ongoing_flush <= 1'b0;
        end
    end

    // Set counter runs one past the last set to mark the end of the walk.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_set <= '0;
            flush_way <= '0;
        end else if (clr_flush) begin
            flush_set <= '0;
            flush_way <= '0;
        end else begin
            if (incr_flush_way) flush_way <= flush_way + 1'b1;
            if (incr_flush_set) flush_set <= flush_set + 1'b1;
        end
    end

    a_set_clr: assert property (@(posedge clk) disable iff (!rst)
        !(set_ongoing_flush && clr_ongoing_flush));

    // Steps only come from a walk in progress.
    a_step_in_flush: assert property (@(posedge clk) disable iff (!rst)
        incr_flush_way |-> ongoing_flush);

endmodule

// ==== source/l2_reqs_slots.sv ====
/* Free request slot counter. CPU requests take a slot, responses return one. */

`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_reqs_slots import l2_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc,
    input  logic                     free,
    output logic [`REQS_BITS_P1-1:0] reqs_cnt
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reqs_cnt <= `REQS_BITS_P1'(`N_REQS); // All slots free.
        end else if (alloc && !free) begin
            reqs_cnt <= reqs_cnt - 1'b1;
        end else if (free && !alloc) begin
            reqs_cnt <= reqs_cnt + 1'b1;
        end
    end

    // Decoder must not take a slot that is not there.
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> reqs_cnt != '0);

    // A response with no request outstanding.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        free |-> reqs_cnt != `REQS_BITS_P1'(`N_REQS));

endmodule

// ==== source/l2_input_decoder.sv ====
/* L2 input decoder.
   Picks one message per cycle by fixed priority and registers the decoded operation. */

`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_input_decoder import l2_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_ready,
    input  logic                     flush_valid_int,
    input  logic                     rsp_valid_int,
    input  logic                     fwd_valid_int,
    input  logic                     cpu_valid_int,
    input  line_addr_t               rsp_addr_int,
    input  line_addr_t               fwd_addr_int,
    input  addr_t                    cpu_addr_int,
    input  logic [`REQS_BITS_P1-1:0] reqs_cnt,
    input  logic                     ongoing_flush,
    input  logic [`L2_SET_BITS:0]    flush_set,
    input  logic [`L2_WAY_BITS-1:0]  flush_way,
    output logic                     flush_ready_int,
    output logic                     rsp_ready_int,
    output logic                     fwd_ready_int,
    output logic                     cpu_ready_int,
    output logic                     set_ongoing_flush,
    output logic                     clr_ongoing_flush,
    output logic                     incr_flush_way,
    output logic                     incr_flush_set,
    output logic                     clr_flush,
    output logic                     alloc,
    output logic                     free,
    output logic                     op_valid,
    output l2_op_t                   op_kind,
    output tag_t                     op_tag,
    output set_t                     op_set,
    output way_t                     op_way,
    output line_addr_t               op_line_addr,
    output w_off_t                   op_w_off,
    output b_off_t                   op_b_off,
    output logic                     flush_done
);

    logic decode_en;
    logic do_flush_next, do_rsp_next, do_fwd_next, do_flush_way_next, do_cpu_req_next;
    logic flush_done_next;
    logic op_valid_next;
    l2_op_t op_kind_next;
    tag_t op_tag_next;
    set_t op_set_next;
    way_t op_way_next;
    line_addr_t op_line_addr_next;
    w_off_t op_w_off_next;
    b_off_t op_b_off_next;
    line_breakdown_t rsp_br, fwd_br;
    addr_breakdown_t cpu_br;

    assign decode_en = !op_valid || op_ready; // Output register free or draining.

    assign rsp_br = break_line(rsp_addr_int);
    assign fwd_br = break_line(fwd_addr_int);
    assign cpu_br = break_addr(cpu_addr_int);

    always_comb begin
        do_flush_next = 1'b0;
        do_rsp_next = 1'b0;
        do_fwd_next = 1'b0;
        do_flush_way_next = 1'b0;
        do_cpu_req_next = 1'b0;
        flush_done_next = 1'b0;
        if (decode_en) begin
            if (flush_valid_int && reqs_cnt == `N_REQS) begin
                do_flush_next = 1'b1; // Only once every slot is back.
            end else if (rsp_valid_int) begin
                do_rsp_next = 1'b1;
            end else if (fwd_valid_int) begin
                do_fwd_next = 1'b1;
            end else if (ongoing_flush) begin
                if (flush_set < `L2_SETS) do_flush_way_next = 1'b1;
                else flush_done_next = 1'b1;
            end else if (cpu_valid_int && reqs_cnt != '0) begin
                do_cpu_req_next = 1'b1;
            end
        end
    end

    assign flush_ready_int = do_flush_next;
    assign rsp_ready_int = do_rsp_next;
    assign fwd_ready_int = do_fwd_next;
    assign cpu_ready_int = do_cpu_req_next;

    // Walker commands.
    assign set_ongoing_flush = do_flush_next;
    assign clr_ongoing_flush = flush_done_next;
    assign clr_flush = flush_done_next;
    assign incr_flush_way = do_flush_way_next; // Way wraps to zero on its own.
    assign incr_flush_set = do_flush_way_next && (flush_way == `L2_WAY_BITS'(`L2_WAYS - 1));

    assign alloc = do_cpu_req_next;
    assign free = do_rsp_next;

    assign op_valid_next = do_rsp_next || do_fwd_next || do_flush_way_next || do_cpu_req_next;

    always_comb begin
        op_kind_next = OP_CPU_REQ;
        op_tag_next = '0;
        op_set_next = '0;
        op_way_next = '0;
        op_line_addr_next = '0;
        op_w_off_next = '0;
        op_b_off_next = '0;
        if (do_rsp_next) begin
            op_kind_next = OP_RSP;
            op_tag_next = rsp_br.tag;
            op_set_next = rsp_br.set;
            op_line_addr_next = rsp_addr_int;
        end else if (do_fwd_next) begin
            op_kind_next = OP_FWD;
            op_tag_next = fwd_br.tag;
            op_set_next = fwd_br.set;
            op_line_addr_next = fwd_addr_int;
        end else if (do_flush_way_next) begin
            op_kind_next = OP_FLUSH_WAY;
            op_set_next = flush_set[`L2_SET_BITS-1:0];
            op_way_next = flush_way;
            op_line_addr_next = line_addr_t'(flush_set[`L2_SET_BITS-1:0]);
        end else if (do_cpu_req_next) begin
            op_tag_next = cpu_br.tag;
            op_set_next = cpu_br.set;
            op_line_addr_next = cpu_br.line_addr;
            op_w_off_next = cpu_br.w_off;
            op_b_off_next = cpu_br.b_off;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_valid <= 1'b0;
            flush_done <= 1'b0;
        end else if (decode_en) begin
            op_valid <= op_valid_next;
            flush_done <= flush_done_next;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            op_kind <= op_kind_next;
            op_tag <= op_tag_next;
            op_set <= op_set_next;
            op_way <= op_way_next;
            op_line_addr <= op_line_addr_next;
            op_w_off <= op_w_off_next;
            op_b_off <= op_b_off_next;
        end
    end

    a_one_pop: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({flush_ready_int, rsp_ready_int, fwd_ready_int, cpu_ready_int}));

endmodule

// ==== source/l2_input_top.sv ====
/* L2 input stage top.
   Channel buffers, decoder, flush walker and request slot counter. */

`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_input_top import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_valid,
    output logic       flush_ready,
    input  logic       rsp_valid,
    output logic       rsp_ready,
    input  line_addr_t rsp_addr,
    input  logic       fwd_valid,
    output logic       fwd_ready,
    input  line_addr_t fwd_addr,
    input  logic       cpu_valid,
    output logic       cpu_ready,
    input  addr_t      cpu_addr,
    output logic       op_valid,
    input  logic       op_ready,
    output l2_op_t     op_kind,
    output tag_t       op_tag,
    output set_t       op_set,
    output way_t       op_way,
    output line_addr_t op_line_addr,
    output w_off_t     op_w_off,
    output b_off_t     op_b_off,
    output logic       flush_done
);

    logic flush_valid_int, rsp_valid_int, fwd_valid_int, cpu_valid_int;
    logic flush_ready_int, rsp_ready_int, fwd_ready_int, cpu_ready_int;
    line_addr_t rsp_addr_int, fwd_addr_int;
    addr_t cpu_addr_int;
    logic set_ongoing_flush, clr_ongoing_flush;
    logic incr_flush_way, incr_flush_set, clr_flush;
    logic ongoing_flush;
    logic [`L2_SET_BITS:0] flush_set;
    way_t flush_way;
    logic alloc, free;
    logic [`REQS_BITS_P1-1:0] reqs_cnt;

    // Flush carries no data.
    l2_input_fifo #(.payload_t(logic)) i_flush_fifo (
        .clk(clk), .rst(rst),
        .in_valid(flush_valid), .in_ready(flush_ready), .in_data(1'b0),
        .out_valid(flush_valid_int), .out_ready(flush_ready_int), .out_data()
    );

    l2_input_fifo #(.payload_t(line_addr_t)) i_rsp_fifo (
        .clk(clk), .rst(rst),
        .in_valid(rsp_valid), .in_ready(rsp_ready), .in_data(rsp_addr),
        .out_valid(rsp_valid_int), .out_ready(rsp_ready_int), .out_data(rsp_addr_int)
    );

    l2_input_fifo #(.payload_t(line_addr_t)) i_fwd_fifo (
        .clk(clk), .rst(rst),
        .in_valid(fwd_valid), .in_ready(fwd_ready), .in_data(fwd_addr),
        .out_valid(fwd_valid_int), .out_ready(fwd_ready_int), .out_data(fwd_addr_int)
    );

    l2_input_fifo #(.payload_t(addr_t)) i_cpu_fifo (
        .clk(clk), .rst(rst),
        .in_valid(cpu_valid), .in_ready(cpu_ready), .in_data(cpu_addr),
        .out_valid(cpu_valid_int), .out_ready(cpu_ready_int), .out_data(cpu_addr_int)
    );

    l2_input_decoder i_l2_input_decoder (
        .clk(clk), .rst(rst), .op_ready(op_ready),
        .flush_valid_int(flush_valid_int), .rsp_valid_int(rsp_valid_int),
        .fwd_valid_int(fwd_valid_int), .cpu_valid_int(cpu_valid_int),
        .rsp_addr_int(rsp_addr_int), .fwd_addr_int(fwd_addr_int),
        .cpu_addr_int(cpu_addr_int), .reqs_cnt(reqs_cnt),
        .ongoing_flush(ongoing_flush), .flush_set(flush_set), .flush_way(flush_way),
        .flush_ready_int(flush_ready_int), .rsp_ready_int(rsp_ready_int),
        .fwd_ready_int(fwd_ready_int), .cpu_ready_int(cpu_ready_int),
        .set_ongoing_flush(set_ongoing_flush), .clr_ongoing_flush(clr_ongoing_flush),
        .incr_flush_way(incr_flush_way), .incr_flush_set(incr_flush_set),
        .clr_flush(clr_flush), .alloc(alloc), .free(free),
        .op_valid(op_valid), .op_kind(op_kind), .op_tag(op_tag), .op_set(op_set),
        .op_way(op_way), .op_line_addr(op_line_addr), .op_w_off(op_w_off),
        .op_b_off(op_b_off), .flush_done(flush_done)
    );

    l2_flush_walker i_l2_flush_walker (
        .clk(clk), .rst(rst),
        .set_ongoing_flush(set_ongoing_flush), .clr_ongoing_flush(clr_ongoing_flush),
        .incr_flush_way(incr_flush_way), .incr_flush_set(incr_flush_set),
        .clr_flush(clr_flush), .ongoing_flush(ongoing_flush),
        .flush_set(flush_set), .flush_way(flush_way)
    );

    l2_reqs_slots i_l2_reqs_slots (
        .clk(clk), .rst(rst), .alloc(alloc), .free(free), .reqs_cnt(reqs_cnt)
    );

endmodule

// ==== testbench/tb_l2_input.sv ====
/* Testbench for the L2 input stage.
   Random traffic on all channels, decoded operations checked against queue models. */

`timescale 1ns/1ps
`include "l2_cfg.svh"

module tb_l2_input import l2_pkg::*; ();

    localparam int RANDOM_CYCLES = 4000;
    localparam int FLUSH_OPS = `L2_SETS * `L2_WAYS;
    localparam int IDLE_LIMIT = 1000;
    localparam int WAIT_LIMIT = 5000;

    logic clk, rst;
    logic flush_valid, flush_ready, rsp_valid, rsp_ready, fwd_valid, fwd_ready;
    logic cpu_valid, cpu_ready, op_valid, op_ready, flush_done;
    line_addr_t rsp_addr, fwd_addr, op_line_addr;
    addr_t cpu_addr;
    l2_op_t op_kind;
    tag_t op_tag;
    set_t op_set;
    way_t op_way;
    w_off_t op_w_off;
    b_off_t op_b_off;

    // Reference model.
    line_addr_t rsp_q[$];
    line_addr_t fwd_q[$];
    addr_t cpu_q[$];
    int model_cnt = `N_REQS;
    int flush_in_q, flush_idx, flush_dones, cpu_seen, progress_cycle, op_cnt;
    int mismatch_cnt, other_cnt;
    bit rsp_fire, fwd_fire, cpu_fire, flush_fire, held;
    logic [63:0] held_fields;

    // Stimulus side.
    int rsp_sent, flush_starts, cycle_cnt, wait_cnt;
    bit force_flush, stuck;

    l2_input_top i_l2_input_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] op_fields();
        return {op_kind, op_tag, op_set, op_way, op_line_addr, op_w_off, op_b_off};
    endfunction

    function automatic bit flush_pending();
        return flush_starts != flush_dones;
    endfunction

    function automatic bit drained();
        return rsp_q.size() == 0 && fwd_q.size() == 0 && cpu_q.size() == 0
            && flush_in_q == 0 && !flush_pending() && rsp_sent == cpu_seen
            && !(rsp_valid || fwd_valid || cpu_valid || flush_valid || op_valid);
    endfunction

    task automatic report_error(input string what);
        $display("%0t: %s", $time, what);
        other_cnt++;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endtask

    // Line address splits into tag above set.
    task automatic check_line(input line_addr_t la);
        logic [31:0] line;
        line = 32'(la);
        check_field("op_tag", 32'(op_tag), line / `L2_SETS);
        check_field("op_set", 32'(op_set), line % `L2_SETS);
        check_field("op_line_addr", 32'(op_line_addr), line);
    endtask

    task automatic check_op();
        addr_t a;
        op_cnt++;
        case (op_kind)
            OP_RSP: begin
                if (rsp_q.size() == 0) report_error("OP_RSP with no response queued");
                else check_line(rsp_q.pop_front());
                model_cnt++;
                if (model_cnt > `N_REQS) report_error("response freed a slot never taken");
            end
            OP_FWD: begin
                if (fwd_q.size() == 0) report_error("OP_FWD with no forward queued");
                else check_line(fwd_q.pop_front());
            end
            OP_CPU_REQ: begin
                if (model_cnt == 0) report_error("OP_CPU_REQ issued with no free slot");
                else model_cnt--;
                if (flush_idx != 0) report_error("OP_CPU_REQ issued inside a flush walk");
                cpu_seen++;
                if (cpu_q.size() == 0) begin
                    report_error("OP_CPU_REQ with no CPU request queued");
                end else begin
                    a = cpu_q.pop_front();
                    check_line(line_addr_t'(a >> `OFFSET_BITS));
                    check_field("op_w_off", 32'(op_w_off),
                                (32'(a) % (1 << `OFFSET_BITS)) >> `B_OFF_BITS);
                    check_field("op_b_off", 32'(op_b_off), 32'(a) % (1 << `B_OFF_BITS));
                end
            end
            default: begin
                if (flush_in_q == 0) begin
                    report_error("OP_FLUSH_WAY with no flush accepted");
                end else if (flush_idx >= FLUSH_OPS) begin
                    report_error("more flush operations than sets times ways");
                end else begin
                    if (flush_idx == 0 && model_cnt != `N_REQS)
                        report_error($sformatf("flush walk started with %0d of %0d slots free",
                                               model_cnt, `N_REQS));
                    check_field("op_set", 32'(op_set), 32'(flush_idx / `L2_WAYS)); // Set-major.
                    check_field("op_way", 32'(op_way), 32'(flush_idx % `L2_WAYS));
                end
                flush_idx++;
            end
        endcase
    endtask

    task automatic check_flush_done();
        if (flush_in_q == 0) report_error("flush_done pulsed with no flush accepted");
        else if (flush_idx != FLUSH_OPS)
            report_error($sformatf("flush_done after %0d flush operations, %0d expected",
                                   flush_idx, FLUSH_OPS));
        if (flush_in_q > 0) flush_in_q--;
        flush_idx = 0;
        flush_dones++;
    endtask

    // Sampled mid-cycle, so each flag tells what happens at the next rising edge.
    always @(negedge clk) begin
        if (rst) begin
            if (held && !op_valid) report_error("op_valid dropped while op_ready was low");
            else if (held && op_fields() !== held_fields) begin
                $display("mismatch op_* fields while stalled: got 0x%h expected 0x%h at %0t",
                         op_fields(), held_fields, $time);
                mismatch_cnt++;
            end
            held = op_valid && !op_ready;
            held_fields = op_fields();
            rsp_fire = rsp_valid && rsp_ready;
            fwd_fire = fwd_valid && fwd_ready;
            cpu_fire = cpu_valid && cpu_ready;
            flush_fire = flush_valid && flush_ready;
            if (rsp_fire) rsp_q.push_back(rsp_addr);
            if (fwd_fire) fwd_q.push_back(fwd_addr);
            if (cpu_fire) cpu_q.push_back(cpu_addr);
            if (flush_fire) flush_in_q++;
            if (op_valid && op_ready) begin
                check_op();
                progress_cycle = cycle_cnt;
            end
            if (flush_done) begin
                check_flush_done();
                progress_cycle = cycle_cnt;
            end
        end
    end

    task automatic drive_inputs(input bit stim_on);
        op_ready = stim_on ? ($urandom_range(99, 0) >= 30) : 1'b1;
        if (rsp_fire) rsp_valid = 1'b0;
        if (fwd_fire) fwd_valid = 1'b0;
        if (cpu_fire) cpu_valid = 1'b0;
        if (flush_fire) flush_valid = 1'b0;
        if (!rsp_valid && rsp_sent < cpu_seen && $urandom_range(3, 0) == 0) begin
            rsp_valid = 1'b1; // Reply to an issued CPU request.
            rsp_addr = line_addr_t'($urandom);
            rsp_sent++;
        end
        if (stim_on && !fwd_valid && $urandom_range(3, 0) == 0) begin
            fwd_valid = 1'b1;
            fwd_addr = line_addr_t'($urandom);
        end
        if (stim_on && !cpu_valid && !flush_pending() && $urandom_range(2, 0) == 0) begin
            cpu_valid = 1'b1;
            cpu_addr = $urandom;
        end
        if (!flush_valid && !flush_pending()
            && (force_flush || (stim_on && $urandom_range(399, 0) == 0))) begin
            flush_valid = 1'b1;
            flush_starts++;
            force_flush = 1'b0;
        end
    endtask

    task automatic step_cycle(input bit stim_on);
        @(posedge clk);
        #2;
        drive_inputs(stim_on);
        cycle_cnt++;
        if (cycle_cnt - progress_cycle > IDLE_LIMIT && !stuck) begin
            report_error($sformatf("timeout, no operation for %0d cycles", IDLE_LIMIT));
            stuck = 1'b1;
        end
    endtask

    initial begin
        rst = 1'b0;
        flush_valid = 1'b0;
        rsp_valid = 1'b0;
        rsp_addr = '0;
        fwd_valid = 1'b0;
        fwd_addr = '0;
        cpu_valid = 1'b0;
        cpu_addr = '0;
        op_ready = 1'b0;
        void'($urandom(21365));
        repeat (16) @(posedge clk);
        check_field("op_valid", 32'(op_valid), 32'd0);
        check_field("flush_done", 32'(flush_done), 32'd0);
        #2;
        rst = 1'b1;
        for (int i = 0; i < RANDOM_CYCLES && !stuck; i++) step_cycle(1'b1);
        force_flush = 1'b1; // One walk under live traffic at the end.
        wait_cnt = 0;
        while ((force_flush || flush_pending()) && wait_cnt < WAIT_LIMIT && !stuck) begin
            step_cycle(1'b1);
            wait_cnt++;
        end
        if (force_flush || flush_pending()) report_error("timeout waiting for flush_done");
        wait_cnt = 0;
        while (!drained() && wait_cnt < WAIT_LIMIT && !stuck) begin
            step_cycle(1'b0);
            wait_cnt++;
        end
        if (!drained())
            report_error($sformatf("timeout draining, %0d rsp, %0d fwd, %0d cpu entries left",
                                   rsp_q.size(), fwd_q.size(), cpu_q.size()));
        if (model_cnt != `N_REQS)
            report_error($sformatf("slot count ends at %0d, %0d expected", model_cnt, `N_REQS));
        $display("errors: %0d mismatches, %0d other, %0d operations, %0d flushes checked",
                 mismatch_cnt, other_cnt, op_cnt, flush_dones);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
source/l2_pkg.sv
source/l2_input_fifo.sv
source/l2_flush_walker.sv
source/l2_reqs_slots.sv
source/l2_input_decoder.sv
source/l2_input_top.sv
testbench/tb_l2_input.sv

// ==== Makefile ====
# Verilator build and run for the L2 input stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_l2_input
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := include/l2_cfg.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
